// ==== Makefile ====
# Verilator build and run of the register file subsystem testbench
TOP := tb_rf_subsystem

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

# The run passes only if the pass line shows up in the output
test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f compile.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir

// ==== axil_pkg.sv ====
// AXI4-Lite package with address and data types, response codes and channel structs
`default_nettype none

package axil_pkg;

  // 4 KiB host window
  typedef logic [11:0] axil_addr_t;
  typedef logic [31:0] axil_data_t;

  // Only OKAY and SLVERR are ever returned
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axil_resp_e;

  // Master-driven fields of all five channels
  typedef struct packed {
    logic       awvalid;
    axil_addr_t awaddr;
    logic       wvalid;
    axil_data_t wdata;
    logic       bready;
    logic       arvalid;
    axil_addr_t araddr;
    logic       rready;
  } axil_req_t;

  // Slave-driven fields
  typedef struct packed {
    logic       awready;
    logic       wready;
    logic       bvalid;
    axil_resp_e bresp;
    logic       arready;
    logic       rvalid;
    axil_data_t rdata;
    axil_resp_e rresp;
  } axil_rsp_t;

endpackage

`default_nettype wire

// ==== axil_rf_slave.sv ====
// AXI4-Lite slave decoding host accesses into register writes, host reads, commands and status
`timescale 1ns/100ps
`default_nettype none

module axil_rf_slave
  import rf_pkg::*;
  import axil_pkg::*;
#(
  parameter int FPU = 1
) (
  input  wire logic       clk,
  input  wire logic       rst_n,

  // Host bus
  input  wire axil_req_t  axil_req_i,
  output axil_rsp_t       axil_rsp_o,

  // Register file write port B
  output rf_write_t       wr_o,

  // Command issue to the execute unit
  output logic            cmd_valid_o,
  output exec_cmd_t       cmd_o,

  // Host read through the arbiter
  output logic            host_req_o,
  output reg_addr_t       host_raddr_o,
  input  wire logic       host_grant_i,
  input  wire reg_data_t  host_rdata_i,

  // Status inputs
  input  wire logic       busy_i,
  input  wire logic [7:0] done_count_i
);

  // What a byte address points at
  typedef enum logic [1:0] {TGT_REG, TGT_CMD, TGT_STATUS, TGT_ERR} target_e;
  typedef enum logic {W_IDLE, W_RESP} wr_state_e;
  typedef enum logic [1:0] {R_IDLE, R_HOST, R_RESP} rd_state_e;

  wr_state_e  w_state_q;
  rd_state_e  r_state_q;
  target_e    w_tgt;
  target_e    r_tgt;
  logic       aw_accept;
  logic       ar_accept;
  axil_resp_e bresp_q;
  axil_resp_e rresp_q;
  reg_data_t  rdata_q;
  reg_addr_t  host_raddr_q;
  exec_cmd_t  last_cmd_q;
  reg_data_t  status_word;

  function automatic target_e decode(axil_addr_t a);
    // Word aligned accesses only
    if (a[1:0] != 2'b00) begin
      return TGT_ERR;
    end else if (a <= ADDR_INT_LAST) begin
      return TGT_REG;
    end else if ((a >= ADDR_FP_FIRST) && (a <= ADDR_FP_LAST)) begin
      return (FPU != 0) ? TGT_REG : TGT_ERR;
    end else if (a == ADDR_CMD) begin
      return TGT_CMD;
    end else if (a == ADDR_STATUS) begin
      return TGT_STATUS;
    end
    return TGT_ERR;
  endfunction

  // ----------------------------------------------------------------------
  // Write side
  // ----------------------------------------------------------------------
  assign w_tgt     = decode(axil_req_i.awaddr);
  // Address and data taken together in one beat
  assign aw_accept = (w_state_q == W_IDLE) && axil_req_i.awvalid && axil_req_i.wvalid;

  // Register index is the word address, bit 7 picks the FP bank
  always_comb begin
    wr_o.en   = aw_accept && (w_tgt == TGT_REG);
    wr_o.addr = reg_addr_t'(axil_req_i.awaddr[7:2]);
    wr_o.data = axil_req_i.wdata;
  end

  assign cmd_valid_o = aw_accept && (w_tgt == TGT_CMD);
  assign cmd_o       = exec_cmd_t'(axil_req_i.wdata);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      w_state_q  <= W_IDLE;
      bresp_q    <= RESP_OKAY;
      last_cmd_q <= '0;
    end else begin
      unique case (w_state_q)
        W_IDLE: begin
          if (aw_accept) begin
            w_state_q <= W_RESP;
            bresp_q   <= (w_tgt == TGT_ERR) ? RESP_SLVERR : RESP_OKAY;
          end
          // Kept for read-back at the command address
          if (cmd_valid_o) begin
            last_cmd_q <= cmd_o;
          end
        end
        default: begin
          if (axil_req_i.bready) begin
            w_state_q <= W_IDLE;
          end
        end
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // Read side
  // ----------------------------------------------------------------------
  assign r_tgt       = decode(axil_req_i.araddr);
  assign ar_accept   = (r_state_q == R_IDLE) && axil_req_i.arvalid;
  // busy in bit 0, completion count in bits 15 to 8
  assign status_word = {16'h0000, done_count_i, 7'b0, busy_i};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      r_state_q    <= R_IDLE;
      rresp_q      <= RESP_OKAY;
      rdata_q      <= '0;
      host_raddr_q <= '0;
    end else begin
      unique case (r_state_q)
        R_IDLE: begin
          if (ar_accept) begin
            rresp_q   <= RESP_OKAY;
            r_state_q <= R_RESP;
            unique case (r_tgt)
              TGT_REG: begin
                // Wait for port C
                r_state_q    <= R_HOST;
                host_raddr_q <= reg_addr_t'(axil_req_i.araddr[7:2]);
              end
              TGT_CMD:    rdata_q <= reg_data_t'(last_cmd_q);
              TGT_STATUS: rdata_q <= status_word;
              default: begin
                rdata_q <= '0;
                rresp_q <= RESP_SLVERR;
              end
            endcase
          end
        end
        R_HOST: begin
          if (host_grant_i) begin
            rdata_q   <= host_rdata_i;
            r_state_q <= R_RESP;
          end
        end
        default: begin
          if (axil_req_i.rready) begin
            r_state_q <= R_IDLE;
          end
        end
      endcase
    end
  end

  assign host_req_o   = (r_state_q == R_HOST);
  assign host_raddr_o = host_raddr_q;

  // Response channels
  always_comb begin
    axil_rsp_o.awready = aw_accept;
    axil_rsp_o.wready  = aw_accept;
    axil_rsp_o.bvalid  = (w_state_q == W_RESP);
    axil_rsp_o.bresp   = bresp_q;
    axil_rsp_o.arready = (r_state_q == R_IDLE);
    axil_rsp_o.rvalid  = (r_state_q == R_RESP);
    axil_rsp_o.rdata   = rdata_q;
    axil_rsp_o.rresp   = rresp_q;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
rf_pkg.sv
axil_pkg.sv
riscv_register_file.sv
rf_read_arbiter.sv
rf_execute.sv
axil_rf_slave.sv
rf_subsystem_top.sv
rf_subsystem_sva.sv
tb_rf_subsystem.sv

// ==== rf_execute.sv ====
// Two-stage execute pipeline computing a three-operand result with write-back on port A
`timescale 1ns/100ps
`default_nettype none

module rf_execute
  import rf_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      rst_n,

  // Command issue, always accepted
  input  wire logic      cmd_valid_i,
  input  wire exec_cmd_t cmd_i,

  // Operand reads
  output reg_addr_t      raddr_a_o,
  output reg_addr_t      raddr_b_o,
  input  wire reg_data_t rdata_a_i,
  input  wire reg_data_t rdata_b_i,
  output reg_addr_t      raddr_c_o,
  input  wire reg_data_t rdata_c_i,

  // Result write-back and status
  output rf_write_t      wr_o,
  output logic           busy_o,
  output logic [7:0]     done_count_o
);

  // Operands captured at the accepting edge
  typedef struct packed {
    exec_op_e  op;
    reg_addr_t rd;
    reg_data_t a;
    reg_data_t b;
    reg_data_t c;
  } stage1_t;

  logic       s1_valid_q;
  stage1_t    s1_q;
  logic       s2_valid_q;
  reg_addr_t  s2_rd_q;
  reg_data_t  s2_result_q;
  logic [7:0] done_q;

  function automatic reg_data_t compute(stage1_t s);
    reg_data_t m;
    m = (s.a > s.b) ? s.a : s.b;
    unique case (s.op)
      OP_ADD3: return s.a + s.b + s.c;
      // Product truncated to the low word
      OP_MADD: return s.a * s.b + s.c;
      OP_XOR3: return s.a ^ s.b ^ s.c;
      default: return (m > s.c) ? m : s.c;
    endcase
  endfunction

  // Operand addresses straight from the command word
  assign raddr_a_o = cmd_i.rs1;
  assign raddr_b_o = cmd_i.rs2;
  assign raddr_c_o = cmd_i.rs3;

  // ----------------------------------------------------------------------
  // Pipeline valids and completion count
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
      done_q     <= '0;
    end else begin
      s1_valid_q <= cmd_valid_i;
      s2_valid_q <= s1_valid_q;
      // Counts modulo 256
      if (s2_valid_q) begin
        done_q <= done_q + 8'd1;
      end
    end
  end

  // Payload stages
  always_ff @(posedge clk) begin
    if (cmd_valid_i) begin
      s1_q <= '{op: cmd_i.op, rd: cmd_i.rd, a: rdata_a_i, b: rdata_b_i, c: rdata_c_i};
    end
    if (s1_valid_q) begin
      s2_rd_q     <= s1_q.rd;
      s2_result_q <= compute(s1_q);
    end
  end

  // Write lands at the second edge after acceptance
  assign wr_o         = '{en: s2_valid_q, addr: s2_rd_q, data: s2_result_q};
  assign busy_o       = s1_valid_q || s2_valid_q;
  assign done_count_o = done_q;

endmodule

`default_nettype wire

// ==== rf_pkg.sv ====
// Register file package with register, command and write-port types and the host address map
`default_nettype none

package rf_pkg;

  // ----------------------------------------------------------------------
  // Register types
  // ----------------------------------------------------------------------

  // Bit 5 selects the floating-point bank
  typedef logic [5:0]  reg_addr_t;
  typedef logic [31:0] reg_data_t;

  // Three-operand operations of the execute unit
  typedef enum logic [1:0] {
    OP_ADD3 = 2'd0,   // a + b + c
    OP_MADD = 2'd1,   // low word of a * b, plus c
    OP_XOR3 = 2'd2,   // a ^ b ^ c
    OP_MAX3 = 2'd3    // unsigned maximum
  } exec_op_e;

  // Command word as written by the host, rd in the low bits
  typedef struct packed {
    logic [5:0] spare;
    exec_op_e   op;
    reg_addr_t  rs3;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    reg_addr_t  rd;
  } exec_cmd_t;

  // One write port of the register file
  typedef struct packed {
    logic      en;
    reg_addr_t addr;
    reg_data_t data;
  } rf_write_t;

  // ----------------------------------------------------------------------
  // Host byte address map
  // ----------------------------------------------------------------------
  localparam logic [11:0] ADDR_INT_LAST = 12'h07C;
  localparam logic [11:0] ADDR_FP_FIRST = 12'h080;
  localparam logic [11:0] ADDR_FP_LAST  = 12'h0FC;
  localparam logic [11:0] ADDR_CMD      = 12'h100;
  localparam logic [11:0] ADDR_STATUS   = 12'h104;

endpackage

`default_nettype wire

// ==== rf_read_arbiter.sv ====
// Read port C arbiter between execute operand reads and held host register reads
`timescale 1ns/100ps
`default_nettype none

module rf_read_arbiter
  import rf_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      rst_n,

  // Execute side, owns the port in issue cycles
  input  wire logic      exec_issue_i,
  input  wire reg_addr_t exec_raddr_i,
  output reg_data_t      exec_rdata_o,

  // Host side, request held until the grant pulse
  input  wire logic      host_req_i,
  input  wire reg_addr_t host_raddr_i,
  output logic           host_grant_o,
  output reg_data_t      host_rdata_o,

  // Register file port C
  output reg_addr_t      rf_raddr_o,
  input  wire reg_data_t rf_rdata_i
);

  logic      host_win;
  logic      grant_q;
  reg_data_t host_data_q;

  // Host wins any free cycle, but not again while its grant is still out
  assign host_win = host_req_i && !exec_issue_i && !grant_q;

  // Steering of the shared port
  assign rf_raddr_o   = exec_issue_i ? exec_raddr_i : host_raddr_i;
  assign exec_rdata_o = rf_rdata_i;

  // One-cycle grant pulse
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      grant_q <= 1'b0;
    end else begin
      grant_q <= host_win;
    end
  end

  // Data lands together with the grant
  always_ff @(posedge clk) begin
    if (host_win) begin
      host_data_q <= rf_rdata_i;
    end
  end

  assign host_grant_o = grant_q;
  assign host_rdata_o = host_data_q;

endmodule

`default_nettype wire

// ==== rf_subsystem_sva.sv ====
// Bound assertions on AXI4-Lite response stability and the zero register on read port C
`timescale 1ns/100ps
`default_nettype none

module rf_subsystem_sva
  import rf_pkg::*;
  import axil_pkg::*;
(
  input wire logic      clk,
  input wire logic      rst_n,
  input wire axil_req_t axil_req_i,
  input wire axil_rsp_t axil_rsp_i,
  input wire reg_addr_t rf_raddr_c_i,
  input wire reg_data_t rf_rdata_c_i
);

  // ----------------------------------------------------------------------
  // Response channels hold until the master takes them
  // ----------------------------------------------------------------------
  property p_bvalid_hold;
    @(posedge clk) disable iff (!rst_n)
      (axil_rsp_i.bvalid && !axil_req_i.bready)
        |=> (axil_rsp_i.bvalid && $stable(axil_rsp_i.bresp));
  endproperty

  property p_rvalid_hold;
    @(posedge clk) disable iff (!rst_n)
      (axil_rsp_i.rvalid && !axil_req_i.rready)
        |=> (axil_rsp_i.rvalid && $stable(axil_rsp_i.rdata) && $stable(axil_rsp_i.rresp));
  endproperty

  // x0 on the shared port
  property p_zero_reg;
    @(posedge clk) disable iff (!rst_n)
      (rf_raddr_c_i == '0) |-> (rf_rdata_c_i == '0);
  endproperty

  a_bvalid_hold: assert property (p_bvalid_hold)
    else $error("bvalid dropped or bresp changed before bready");
  a_rvalid_hold: assert property (p_rvalid_hold)
    else $error("rvalid dropped or read response changed before rready");
  a_zero_reg: assert property (p_zero_reg)
    else $error("read port C returned nonzero data for register 0");

endmodule

bind rf_subsystem_top rf_subsystem_sva u_sva (
  .clk          (clk),
  .rst_n        (rst_n),
  .axil_req_i   (axil_req_i),
  .axil_rsp_i   (axil_rsp_o),
  .rf_raddr_c_i (rf_raddr_c),
  .rf_rdata_c_i (rf_rdata_c)
);

`default_nettype wire

// ==== rf_subsystem_top.sv ====
// Operand storage subsystem top joining the AXI slave, read arbiter, execute unit and register file
`timescale 1ns/100ps
`default_nettype none

module rf_subsystem_top
  import rf_pkg::*;
  import axil_pkg::*;
#(
  parameter int FPU = 1
) (
  input  wire logic      clk,
  input  wire logic      rst_n,
  input  wire axil_req_t axil_req_i,
  output axil_rsp_t      axil_rsp_o
);

  // ----------------------------------------------------------------------
  // Interconnect
  // ----------------------------------------------------------------------
  rf_write_t  wr_host;
  rf_write_t  wr_exec;
  logic       cmd_valid;
  exec_cmd_t  cmd;
  logic       host_req;
  reg_addr_t  host_raddr;
  logic       host_grant;
  reg_data_t  host_rdata;
  logic       busy;
  logic [7:0] done_count;
  reg_addr_t  raddr_a;
  reg_addr_t  raddr_b;
  reg_data_t  rdata_a;
  reg_data_t  rdata_b;
  // Port C before and after the arbiter
  reg_addr_t  exec_raddr_c;
  reg_data_t  exec_rdata_c;
  reg_addr_t  rf_raddr_c;
  reg_data_t  rf_rdata_c;

  axil_rf_slave #(
    .FPU (FPU)
  ) u_slave (
    .clk          (clk),
    .rst_n        (rst_n),
    .axil_req_i   (axil_req_i),
    .axil_rsp_o   (axil_rsp_o),
    .wr_o         (wr_host),
    .cmd_valid_o  (cmd_valid),
    .cmd_o        (cmd),
    .host_req_o   (host_req),
    .host_raddr_o (host_raddr),
    .host_grant_i (host_grant),
    .host_rdata_i (host_rdata),
    .busy_i       (busy),
    .done_count_i (done_count)
  );

  // Command issue doubles as the execute claim on port C
  rf_read_arbiter u_arbiter (
    .clk          (clk),
    .rst_n        (rst_n),
    .exec_issue_i (cmd_valid),
    .exec_raddr_i (exec_raddr_c),
    .host_req_i   (host_req),
    .host_raddr_i (host_raddr),
    .host_grant_o (host_grant),
    .host_rdata_o (host_rdata),
    .exec_rdata_o (exec_rdata_c),
    .rf_raddr_o   (rf_raddr_c),
    .rf_rdata_i   (rf_rdata_c)
  );

  rf_execute u_execute (
    .clk          (clk),
    .rst_n        (rst_n),
    .cmd_valid_i  (cmd_valid),
    .cmd_i        (cmd),
    .raddr_a_o    (raddr_a),
    .raddr_b_o    (raddr_b),
    .rdata_a_i    (rdata_a),
    .rdata_b_i    (rdata_b),
    .raddr_c_o    (exec_raddr_c),
    .rdata_c_i    (exec_rdata_c),
    .wr_o         (wr_exec),
    .busy_o       (busy),
    .done_count_o (done_count)
  );

  // Host writes go on port B, the favored one
  riscv_register_file #(
    .FPU (FPU)
  ) u_regfile (
    .clk       (clk),
    .rst_n     (rst_n),
    .raddr_a_i (raddr_a),
    .rdata_a_o (rdata_a),
    .raddr_b_i (raddr_b),
    .rdata_b_o (rdata_b),
    .raddr_c_i (rf_raddr_c),
    .rdata_c_o (rf_rdata_c),
    .wr_a_i    (wr_exec),
    .wr_b_i    (wr_host)
  );

endmodule

`default_nettype wire

// ==== riscv_register_file.sv ====
// Flip-flop register file with three read ports, two write ports and an optional FP bank
`timescale 1ns/100ps
`default_nettype none

module riscv_register_file
  import rf_pkg::*;
#(
  parameter int FPU = 0
) (
  input  wire logic      clk,
  input  wire logic      rst_n,

  // Combinational read ports
  input  wire reg_addr_t raddr_a_i,
  output reg_data_t      rdata_a_o,
  input  wire reg_addr_t raddr_b_i,
  output reg_data_t      rdata_b_o,
  input  wire reg_addr_t raddr_c_i,
  output reg_data_t      rdata_c_o,

  // Write ports, B wins on the same register
  input  wire rf_write_t wr_a_i,
  input  wire rf_write_t wr_b_i
);

  // Integer bank alone, or integer bank plus FP bank above it
  localparam int NUM_TOT_WORDS = (FPU != 0) ? 64 : 32;
  localparam int IDX_W         = (FPU != 0) ? 6 : 5;

  // Entry 0 is x0, entries 32 and up are f0 to f31
  reg_data_t                mem [NUM_TOT_WORDS];
  logic [NUM_TOT_WORDS-1:0] we_a_dec;
  logic [NUM_TOT_WORDS-1:0] we_b_dec;

  // One-hot write enable for a single port
  function automatic logic [NUM_TOT_WORDS-1:0] decode_we(rf_write_t wr);
    logic [NUM_TOT_WORDS-1:0] dec;
    dec = '0;
    for (int i = 0; i < NUM_TOT_WORDS; i++) begin
      // FP addresses never match without the FP bank
      if (wr.en && (wr.addr == reg_addr_t'(i))) begin
        dec[i] = 1'b1;
      end
    end
    return dec;
  endfunction

  // ----------------------------------------------------------------------
  // Read side
  // ----------------------------------------------------------------------
  // Bit 5 only takes part when the FP bank exists
  assign rdata_a_o = mem[raddr_a_i[IDX_W-1:0]];
  assign rdata_b_o = mem[raddr_b_i[IDX_W-1:0]];
  assign rdata_c_o = mem[raddr_c_i[IDX_W-1:0]];

  // ----------------------------------------------------------------------
  // Write side
  // ----------------------------------------------------------------------
  assign we_a_dec = decode_we(wr_a_i);
  assign we_b_dec = decode_we(wr_b_i);

  // x0 has no storage, writes to it fall away
  assign mem[0] = '0;

  for (genvar i = 1; i < NUM_TOT_WORDS; i++) begin : g_reg
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        mem[i] <= '0;
      end else if (we_b_dec[i]) begin
        // Host port takes priority
        mem[i] <= wr_b_i.data;
      end else if (we_a_dec[i]) begin
        mem[i] <= wr_a_i.data;
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb_rf_subsystem.sv ====
// Directed testbench for the operand storage subsystem through its AXI4-Lite host port
`timescale 1ns/100ps
`default_nettype none

module tb_rf_subsystem
  import rf_pkg::*;
  import axil_pkg::*;
;

  localparam int          TIMEOUT = 200;
  localparam int unsigned SEED    = 32'h2e5fd47d;

  logic      clk = 1'b0;
  logic      rst_n;
  axil_req_t req;
  axil_rsp_t rsp;
  // Mirror of x0..x31 and f0..f31
  reg_data_t model [64];
  reg_data_t last_cmd;
  // Commands issued, wraps like the STATUS count
  logic [7:0] cmd_count;
  int        errors;
  int        checks;

  always #50 clk = ~clk;

  rf_subsystem_top #(
    .FPU (1)
  ) UUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .axil_req_i (req),
    .axil_rsp_o (rsp)
  );

  // ----------------------------------------------------------------------
  // Compare tasks
  // ----------------------------------------------------------------------
  task automatic check_data(input reg_data_t got, input reg_data_t exp, input string msg);
    checks++;
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s, got %08h expected %08h", $time, msg, got, exp);
      errors++;
    end
  endtask

  task automatic check_resp(input axil_resp_e got, input axil_resp_e exp, input string msg);
    checks++;
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s, got %s expected %s", $time, msg, got.name(),
               exp.name());
      errors++;
    end
  endtask

  // Result rules of the four ops
  function automatic reg_data_t expected_result(exec_op_e op, reg_data_t a, reg_data_t b,
                                                reg_data_t c);
    reg_data_t prod;
    reg_data_t r;
    case (op)
      OP_ADD3: r = a + b + c;
      OP_MADD: begin
        prod = a * b;
        r = prod + c;
      end
      OP_XOR3: r = a ^ b ^ c;
      default: begin
        r = a;
        if (b > r) r = b;
        if (c > r) r = c;
      end
    endcase
    return r;
  endfunction

  // ----------------------------------------------------------------------
  // AXI4-Lite master tasks
  // ----------------------------------------------------------------------
  // Drive on the rising edge, look at the bus on the falling edge
  task automatic axi_write(input axil_addr_t addr, input reg_data_t data, input int hold,
                           output axil_resp_e resp);
    int t;
    @(posedge clk);
    req.awvalid <= 1'b1;
    req.awaddr  <= addr;
    req.wvalid  <= 1'b1;
    req.wdata   <= data;
    t = 0;
    do begin
      @(negedge clk);
      t++;
    end while (!rsp.awready && t < TIMEOUT);
    if (!rsp.awready) begin
      $display("Timeout: write to %03h was never accepted", addr);
      errors++;
    end
    @(posedge clk);
    req.awvalid <= 1'b0;
    req.wvalid  <= 1'b0;
    t = 0;
    do begin
      @(negedge clk);
      t++;
    end while (!rsp.bvalid && t < TIMEOUT);
    if (!rsp.bvalid) begin
      $display("Timeout: no write response for address %03h", addr);
      errors++;
      resp = RESP_SLVERR;
      return;
    end
    resp = rsp.bresp;
    // bready held low for a while
    for (int i = 0; i < hold; i++) begin
      @(negedge clk);
      if (!rsp.bvalid) begin
        $display("Write response vanished while bready was low at %0t ns", $time);
        errors++;
      end
      check_resp(rsp.bresp, resp, "bresp while bready low");
    end
    @(posedge clk);
    req.bready <= 1'b1;
    @(posedge clk);
    req.bready <= 1'b0;
  endtask

  task automatic axi_read(input axil_addr_t addr, input int hold, output reg_data_t data,
                          output axil_resp_e resp);
    int t;
    @(posedge clk);
    req.arvalid <= 1'b1;
    req.araddr  <= addr;
    t = 0;
    do begin
      @(negedge clk);
      t++;
    end while (!rsp.arready && t < TIMEOUT);
    if (!rsp.arready) begin
      $display("Timeout: read of %03h was never accepted", addr);
      errors++;
    end
    @(posedge clk);
    req.arvalid <= 1'b0;
    // Register reads may wait on port C
    t = 0;
    do begin
      @(negedge clk);
      t++;
    end while (!rsp.rvalid && t < TIMEOUT);
    if (!rsp.rvalid) begin
      $display("Timeout: no read data for address %03h", addr);
      errors++;
      data = '0;
      resp = RESP_SLVERR;
      return;
    end
    data = rsp.rdata;
    resp = rsp.rresp;
    for (int i = 0; i < hold; i++) begin
      @(negedge clk);
      if (!rsp.rvalid) begin
        $display("Read data vanished while rready was low at %0t ns", $time);
        errors++;
      end
      check_data(rsp.rdata, data, "rdata while rready low");
      check_resp(rsp.rresp, resp, "rresp while rready low");
    end
    @(posedge clk);
    req.rready <= 1'b1;
    @(posedge clk);
    req.rready <= 1'b0;
  endtask

  // Read STATUS until the pipeline is empty
  task automatic poll_idle(output reg_data_t status);
    axil_resp_e r;
    int         t;
    t = 0;
    do begin
      axi_read(ADDR_STATUS, 0, status, r);
      t++;
    end while (status[0] && t < TIMEOUT);
    if (status[0]) begin
      $display("Timeout: execute unit still busy after %0d status reads", t);
      errors++;
    end
  endtask

  task automatic check_reg(input int idx);
    axil_addr_t addr;
    reg_data_t  d;
    axil_resp_e r;
    addr = axil_addr_t'(idx) << 2;
    axi_read(addr, 0, d, r);
    check_resp(r, RESP_OKAY, $sformatf("read resp of reg %0d", idx));
    check_data(d, model[idx], $sformatf("read data of reg %0d", idx));
  endtask

  task automatic write_reg(input int idx, input reg_data_t val);
    axil_resp_e r;
    axi_write(axil_addr_t'(idx) << 2, val, 0, r);
    check_resp(r, RESP_OKAY, $sformatf("write resp of reg %0d", idx));
    // x0 keeps zero
    if (idx != 0) begin
      model[idx] = val;
    end
  endtask

  // Write a command and update the model with its result
  task automatic issue_command(input exec_op_e op, input int rd, input int rs1, input int rs2,
                               input int rs3);
    exec_cmd_t  cmd;
    axil_resp_e r;
    cmd.spare = '0;
    cmd.op    = op;
    cmd.rs3   = reg_addr_t'(rs3);
    cmd.rs2   = reg_addr_t'(rs2);
    cmd.rs1   = reg_addr_t'(rs1);
    cmd.rd    = reg_addr_t'(rd);
    last_cmd  = reg_data_t'(cmd);
    axi_write(ADDR_CMD, reg_data_t'(cmd), 0, r);
    check_resp(r, RESP_OKAY, "command write resp");
    cmd_count = cmd_count + 8'd1;
    if (rd != 0) begin
      model[rd] = expected_result(op, model[rs1], model[rs2], model[rs3]);
    end
  endtask

  // ----------------------------------------------------------------------
  // Directed tests
  // ----------------------------------------------------------------------
  task automatic test_reset_values();
    reg_data_t  st;
    axil_resp_e r;
    for (int i = 0; i < 64; i++) begin
      check_reg(i);
    end
    axi_read(ADDR_STATUS, 0, st, r);
    check_data(st, '0, "status after reset");
  endtask

  task automatic test_write_read();
    for (int i = 1; i < 64; i++) begin
      write_reg(i, reg_data_t'($urandom));
    end
    write_reg(0, reg_data_t'($urandom));
    for (int i = 0; i < 64; i++) begin
      check_reg(i);
    end
  endtask

  task automatic test_commands();
    reg_data_t  st;
    reg_data_t  d;
    axil_resp_e r;
    int         rd;
    for (int op = 0; op < 4; op++) begin
      for (int k = 0; k < 3; k++) begin
        poll_idle(st);
        rd = 1 + int'($urandom % 63);
        issue_command(exec_op_e'(op), rd, int'($urandom % 64), int'($urandom % 64),
                      int'($urandom % 64));
        poll_idle(st);
        // Idle, count in bits 15 to 8, all else zero
        check_data(st, {16'h0000, cmd_count, 8'h00}, "status after command");
        check_reg(rd);
      end
    end
    // Command address reads back the last command
    axi_read(ADDR_CMD, 0, d, r);
    check_data(d, last_cmd, "command read-back");
  endtask

  task automatic test_overlap();
    reg_data_t  st;
    reg_data_t  d;
    axil_resp_e r;
    int         t;
    poll_idle(st);
    // Host read of x10 races the two command issues for port C
    fork
      begin
        issue_command(OP_MADD, 20, 1, 2, 3);
        issue_command(OP_MAX3, 33, 4, 5, 40);
      end
      begin
        // Start once the first write response is taken, so the held request
        // meets the issue cycle of the second command
        t = 0;
        do begin
          @(negedge clk);
          t++;
        end while (!(rsp.bvalid && req.bready) && t < TIMEOUT);
        if (!(rsp.bvalid && req.bready)) begin
          $display("Timeout: first command write response was never taken");
          errors++;
        end
        axi_read(axil_addr_t'(10) << 2, 0, d, r);
      end
    join
    check_resp(r, RESP_OKAY, "overlapped read resp");
    check_data(d, model[10], "overlapped read data");
    poll_idle(st);
    check_data(st, {16'h0000, cmd_count, 8'h00}, "status after two commands");
    check_reg(20);
    check_reg(33);
  endtask

  task automatic test_errors();
    reg_data_t  d;
    axil_resp_e r;
    axi_write(12'h200, reg_data_t'($urandom), 4, r);
    check_resp(r, RESP_SLVERR, "write to unmapped 0x200");
    axi_read(12'h200, 4, d, r);
    check_resp(r, RESP_SLVERR, "read of unmapped 0x200");
    // Unaligned and past the map
    axi_write(12'h302, reg_data_t'($urandom), 3, r);
    check_resp(r, RESP_SLVERR, "write to unaligned 0x302");
    axi_read(12'h302, 3, d, r);
    check_resp(r, RESP_SLVERR, "read of unaligned 0x302");
  endtask

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------
  initial begin
    int unsigned seed_ret;
    req    <= '0;
    rst_n  <= 1'b0;
    errors = 0;
    checks = 0;
    cmd_count = '0;
    for (int i = 0; i < 64; i++) begin
      model[i] = '0;
    end
    seed_ret = $urandom(SEED);
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    test_reset_values();
    test_write_read();
    test_commands();
    test_overlap();
    test_errors();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
